// ==== Bender.yml ====
package:
  name: dc_miss_ctrl

export_include_dirs:
  - .

sources:
  - include_dirs:
      - .
    files:
      - dc_pkg.sv
      - dc_req_capture.sv
      - dc_line_store.sv
      - dc_miss_ctrl.sv
      - dc_bus_fill.sv
      - dc_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_bus_mem.sv
      - tb_dc_top.sv

// ==== dc_bus_fill.sv ====
`timescale 1ns/1ps
`include "dc_defs.svh"

module dc_bus_fill import dc_pkg::*; (
	input  logic               clk,
	input  logic               rst_i,
	input  logic               start_i,
	input  logic [`DC_ABW-1:0] adr_i,
	output dc_bus_req_t        bus_o,
	input  logic               ack_i,
	input  logic               err_i,
	input  logic [`DC_DW-1:0]  dat_i,
	output dc_fill_t           fill_o
);

	localparam int              BW        = $clog2(`DC_LINE_WORDS);
	localparam logic [BW-1:0]   LAST_BEAT = BW'(`DC_LINE_WORDS - 1);
	// Byte offset between beats
	localparam int              WSH       = $clog2(`DC_DW / 8);

	// Cycle type codes
	localparam logic [2:0] CTI_INCR = 3'b010;
	localparam logic [2:0] CTI_END  = 3'b111;

	logic               active_q;
	logic [BW-1:0]      beat_q;
	logic               done_q;
	logic               err_q;
	logic [`DC_ABW-1:0] base_q;
	dc_line_t           line_q;

	logic               beat_end;

	// Beat finishes on either ack or err
	assign beat_end = active_q && (ack_i || err_i);

	// ======================================================================
	// Burst control
	// ======================================================================

	always_ff @(posedge clk) begin
		if (rst_i) begin
			active_q <= 1'b0;
			beat_q   <= '0;
			done_q   <= 1'b0;
			err_q    <= 1'b0;
		end else begin
			done_q <= 1'b0;
			if (start_i) begin
				active_q <= 1'b1;
				beat_q   <= '0;
				err_q    <= 1'b0;
			end else if (beat_end) begin
				beat_q <= beat_q + 1'b1;
				// Error ends the burst at once
				if (err_i) begin
					active_q <= 1'b0;
					done_q   <= 1'b1;
					err_q    <= 1'b1;
				end else if (beat_q == LAST_BEAT) begin
					active_q <= 1'b0;
					done_q   <= 1'b1;
				end
			end
		end
	end

	// Line base and assembled words
	always_ff @(posedge clk) begin
		if (start_i)
			base_q <= adr_i;
		if (beat_end && !err_i)
			line_q.w[beat_q] <= dat_i;
	end

	// Address steps one word per beat
	assign bus_o.cyc = active_q;
	assign bus_o.stb = active_q;
	assign bus_o.adr = base_q + (`DC_ABW'(beat_q) << WSH);
	assign bus_o.cti = (beat_q == LAST_BEAT) ? CTI_END : CTI_INCR;

	assign fill_o.done = done_q;
	assign fill_o.err  = err_q;
	assign fill_o.line = line_q;

endmodule

// ==== dc_defs.svh ====
`ifndef DC_DEFS_SVH
`define DC_DEFS_SVH

// ======================================================================
// Address and data geometry
// ======================================================================

// Byte address width of the CPU side
`define DC_ABW 16
// Width of one data word
`define DC_DW 32
// Words per cache line
`define DC_LINE_WORDS 4

// ======================================================================
// Cache depths and latencies
// ======================================================================

`define DC_L1_LINES 16
`define DC_L2_LINES 64
// Cycles from a read strobe to the store answer
`define DC_STORE_LAT 1
// Extra wait before an L2 line is used
`define DC_L2_READ_LAT 2
// Settle time after an L1 write
`define DC_L1_WRITE_LAT 2

`endif

// ==== dc_line_store.sv ====
`timescale 1ns/1ps
`include "dc_defs.svh"

module dc_line_store import dc_pkg::*; #(
	parameter int LINES = `DC_L1_LINES
) (
	input  logic          clk,
	input  logic          rst_i,
	input  dc_store_cmd_t cmd_i,
	output dc_store_rsp_t rsp_o,
	output logic          init_done_o
);

	// Line geometry
	localparam int NB = `DC_LINE_WORDS * `DC_DW / 8;
	localparam int OW = $clog2(NB);
	localparam int IW = $clog2(LINES);
	localparam int TW = `DC_ABW - OW - IW;
	localparam int LB = $bits(dc_line_t);

	logic [TW-1:0]  tag_mem [LINES];
	logic [LB-1:0]  data_mem [LINES];
	logic [LINES-1:0] valid_q;

	logic [IW-1:0] idx;
	logic [TW-1:0] tag;
	logic [LB-1:0] wr_bits;

	logic          init_done_q;
	logic [IW-1:0] sweep_q;

	// Read answer pipeline, last stage drives rsp_o
	dc_store_rsp_t rsp_pipe [`DC_STORE_LAT];

	assign idx     = cmd_i.adr[OW +: IW];
	assign tag     = cmd_i.adr[`DC_ABW-1 -: TW];
	assign wr_bits = cmd_i.line;

	// ======================================================================
	// Valid bits and reset sweep
	// ======================================================================

	// One line per cycle is cleared after reset
	always_ff @(posedge clk) begin
		if (rst_i) begin
			init_done_q <= 1'b0;
			sweep_q     <= '0;
		end else if (!init_done_q) begin
			valid_q[sweep_q] <= 1'b0;
			sweep_q          <= sweep_q + 1'b1;
			if (sweep_q == IW'(LINES - 1))
				init_done_q <= 1'b1;
		end else if (cmd_i.inv) begin
			valid_q[idx] <= 1'b0;
		end else if (cmd_i.wr) begin
			valid_q[idx] <= 1'b1;
		end
	end

	// ======================================================================
	// Tag and data arrays
	// ======================================================================

	// Byte masked write, a full mask loads a whole line
	always_ff @(posedge clk) begin
		if (cmd_i.wr) begin
			tag_mem[idx] <= tag;
			for (int b = 0; b < NB; b++) begin
				if (cmd_i.mask[b])
					data_mem[idx][b*8 +: 8] <= wr_bits[b*8 +: 8];
			end
		end
	end

	// First stage holds its answer until the next read
	always_ff @(posedge clk) begin
		if (cmd_i.rd) begin
			rsp_pipe[0].hit  <= valid_q[idx] && (tag_mem[idx] == tag);
			rsp_pipe[0].line <= data_mem[idx];
		end
		for (int s = 1; s < `DC_STORE_LAT; s++)
			rsp_pipe[s] <= rsp_pipe[s-1];
	end

	assign rsp_o       = rsp_pipe[`DC_STORE_LAT-1];
	assign init_done_o = init_done_q;

endmodule

// ==== dc_miss_ctrl.sv ====
`timescale 1ns/1ps
`include "dc_defs.svh"

module dc_miss_ctrl import dc_pkg::*; (
	input  logic               clk,
	input  logic               rst_i,
	input  logic               req_pend_i,
	input  dc_req_t            req_i,
	input  logic               inv_pend_i,
	input  logic [`DC_ABW-1:0] inv_adr_i,
	output logic               take_req_o,
	output logic               take_inv_o,
	output logic               idle_o,
	output dc_store_cmd_t      l1_cmd_o,
	input  dc_store_rsp_t      l1_rsp_i,
	output dc_store_cmd_t      l2_cmd_o,
	input  dc_store_rsp_t      l2_rsp_i,
	input  logic               l1_init_i,
	input  logic               l2_init_i,
	output logic               fill_start_o,
	output logic [`DC_ABW-1:0] fill_adr_o,
	input  dc_fill_t           fill_i,
	output logic               done_o,
	output logic [`DC_DW-1:0]  rdata_o,
	output logic               err_o,
	output logic [31:0]        fill_cnt_o
);

	localparam int NB = `DC_LINE_WORDS * `DC_DW / 8;
	localparam int OW = $clog2(NB);
	localparam int BW = $clog2(`DC_DW / 8);
	localparam int WW = $clog2(`DC_LINE_WORDS);

	// Last count value of each wait
	localparam logic [2:0] LOOKUP_LAST = 3'(`DC_STORE_LAT - 1);
	localparam logic [2:0] L2_LAST     = 3'(`DC_L2_READ_LAT - 1);
	localparam logic [2:0] WR_LAST     = 3'(`DC_L1_WRITE_LAT - 1);

	typedef enum logic [3:0] {
		ST_INIT, ST_IDLE, ST_INV, ST_LOOKUP, ST_L2WAIT,
		ST_L1LOAD, ST_FILL, ST_FILLLOAD, ST_WRWAIT
	} state_e;

	state_e             state_q;
	logic [2:0]         cnt_q;
	dc_req_t            op_q;
	logic [`DC_ABW-1:0] adr_q;
	dc_line_t           line_q;

	logic               lookup_rdy;
	logic [`DC_ABW-1:0] line_adr;
	logic [WW-1:0]      word_sel;
	logic [NB-1:0]      wmask;
	dc_line_t           wline;

	// ======================================================================
	// Handshake and store commands
	// ======================================================================

	// Invalidate goes ahead of a waiting request
	assign idle_o     = (state_q == ST_IDLE);
	assign take_inv_o = idle_o && inv_pend_i;
	assign take_req_o = idle_o && !inv_pend_i && req_pend_i;

	assign lookup_rdy = (cnt_q == LOOKUP_LAST);
	assign line_adr   = {(idle_o ? req_i.adr[`DC_ABW-1:OW] : adr_q[`DC_ABW-1:OW]), {OW{1'b0}}};
	assign word_sel   = adr_q[BW +: WW];

	// Byte lanes of the addressed word, data copied into every word
	assign wmask   = NB'(op_q.sel) << {word_sel, {BW{1'b0}}};
	assign wline.w = {`DC_LINE_WORDS{op_q.wdat}};

	always_comb begin
		l1_cmd_o      = '0;
		l2_cmd_o      = '0;
		l1_cmd_o.adr  = line_adr;
		l2_cmd_o.adr  = line_adr;
		l1_cmd_o.mask = '1;
		l2_cmd_o.mask = '1;
		l1_cmd_o.line = line_q;
		l2_cmd_o.line = line_q;
		case (state_q)
			// Both levels are looked up together
			ST_IDLE: begin
				l1_cmd_o.rd = take_req_o;
				l2_cmd_o.rd = take_req_o;
			end
			ST_INV:
				l1_cmd_o.inv = 1'b1;
			// Write only where the line already lives
			ST_LOOKUP: begin
				l1_cmd_o.wr   = lookup_rdy && op_q.wr && l1_rsp_i.hit;
				l2_cmd_o.wr   = lookup_rdy && op_q.wr && l2_rsp_i.hit;
				l1_cmd_o.mask = wmask;
				l2_cmd_o.mask = wmask;
				l1_cmd_o.line = wline;
				l2_cmd_o.line = wline;
			end
			ST_L1LOAD:
				l1_cmd_o.wr = 1'b1;
			ST_FILLLOAD: begin
				l1_cmd_o.wr = 1'b1;
				l2_cmd_o.wr = 1'b1;
			end
			default: ;
		endcase
	end

	// ======================================================================
	// Miss sequencing FSM
	// ======================================================================

	always_ff @(posedge clk) begin
		if (rst_i) begin
			state_q      <= ST_INIT;
			cnt_q        <= '0;
			done_o       <= 1'b0;
			err_o        <= 1'b0;
			fill_start_o <= 1'b0;
			fill_cnt_o   <= '0;
		end else begin
			done_o       <= 1'b0;
			err_o        <= 1'b0;
			fill_start_o <= 1'b0;
			case (state_q)
				// Wait out both valid sweeps
				ST_INIT:
					if (l1_init_i && l2_init_i)
						state_q <= ST_IDLE;
				ST_IDLE: begin
					cnt_q <= '0;
					if (inv_pend_i)
						state_q <= ST_INV;
					else if (req_pend_i)
						state_q <= ST_LOOKUP;
				end
				ST_INV:
					state_q <= ST_IDLE;
				ST_LOOKUP: begin
					cnt_q <= cnt_q + 3'd1;
					if (lookup_rdy) begin
						cnt_q <= '0;
						if (op_q.wr || l1_rsp_i.hit) begin
							done_o  <= 1'b1;
							state_q <= ST_IDLE;
						end else if (l2_rsp_i.hit) begin
							state_q <= ST_L2WAIT;
						end else begin
							// Miss in both levels
							fill_start_o <= 1'b1;
							state_q      <= ST_FILL;
						end
					end
				end
				ST_L2WAIT: begin
					cnt_q <= cnt_q + 3'd1;
					if (cnt_q == L2_LAST)
						state_q <= ST_L1LOAD;
				end
				ST_L1LOAD: begin
					cnt_q   <= '0;
					state_q <= ST_WRWAIT;
				end
				// Failed fill loads nothing
				ST_FILL:
					if (fill_i.done) begin
						if (fill_i.err) begin
							done_o  <= 1'b1;
							err_o   <= 1'b1;
							state_q <= ST_IDLE;
						end else begin
							state_q <= ST_FILLLOAD;
						end
					end
				ST_FILLLOAD: begin
					fill_cnt_o <= fill_cnt_o + 32'd1;
					cnt_q      <= '0;
					state_q    <= ST_WRWAIT;
				end
				// L1 write must settle before the word goes back
				ST_WRWAIT: begin
					cnt_q <= cnt_q + 3'd1;
					if (cnt_q == WR_LAST) begin
						done_o  <= 1'b1;
						state_q <= ST_IDLE;
					end
				end
				default:
					state_q <= ST_IDLE;
			endcase
		end
	end

	// Request copy, working line and read word
	always_ff @(posedge clk) begin
		if (take_inv_o)
			adr_q <= inv_adr_i;
		if (take_req_o) begin
			op_q  <= req_i;
			adr_q <= req_i.adr;
		end
		if (state_q == ST_LOOKUP && lookup_rdy) begin
			line_q     <= l2_rsp_i.line;
			fill_adr_o <= {adr_q[`DC_ABW-1:OW], {OW{1'b0}}};
			if (l1_rsp_i.hit)
				rdata_o <= l1_rsp_i.line.w[word_sel];
		end
		if (state_q == ST_FILL && fill_i.done)
			line_q <= fill_i.line;
		if (state_q == ST_WRWAIT && cnt_q == WR_LAST)
			rdata_o <= line_q.w[word_sel];
	end

endmodule

// ==== dc_pkg.sv ====
`include "dc_defs.svh"

package dc_pkg;

	// One CPU request, held until the controller takes it
	typedef struct packed {
		logic                 rd;
		logic                 wr;
		logic [`DC_ABW-1:0]   adr;
		logic [`DC_DW-1:0]    wdat;
		logic [`DC_DW/8-1:0]  sel;
	} dc_req_t;

	// Word 0 sits in the low bits
	typedef struct packed {
		logic [`DC_LINE_WORDS-1:0][`DC_DW-1:0] w;
	} dc_line_t;

	// Command to a line store
	typedef struct packed {
		logic                                rd;
		logic                                wr;
		logic                                inv;
		logic [`DC_ABW-1:0]                  adr;
		logic [`DC_LINE_WORDS*`DC_DW/8-1:0]  mask;
		dc_line_t                            line;
	} dc_store_cmd_t;

	typedef struct packed {
		logic     hit;
		dc_line_t line;
	} dc_store_rsp_t;

	// Burst master outputs
	typedef struct packed {
		logic               cyc;
		logic               stb;
		logic [`DC_ABW-1:0] adr;
		logic [2:0]         cti;
	} dc_bus_req_t;

	// Result of one bus fill
	typedef struct packed {
		logic     done;
		logic     err;
		dc_line_t line;
	} dc_fill_t;

endpackage

// ==== dc_req_capture.sv ====
`timescale 1ns/1ps
`include "dc_defs.svh"

module dc_req_capture import dc_pkg::*; (
	input  logic               clk,
	input  logic               rst_i,
	input  logic               req_valid_i,
	input  dc_req_t            req_i,
	input  logic               inv_i,
	input  logic [`DC_ABW-1:0] inv_adr_i,
	input  logic               take_req_i,
	input  logic               take_inv_i,
	input  logic               ctrl_idle_i,
	output logic               req_pend_o,
	output dc_req_t            req_o,
	output logic               inv_pend_o,
	output logic [`DC_ABW-1:0] inv_adr_o,
	output logic               busy_o
);

	logic               req_pend_q;
	logic               inv_pend_q;
	dc_req_t            req_q;
	logic [`DC_ABW-1:0] inv_adr_q;

	// Pending flags
	// A new strobe wins over a take in the same cycle
	always_ff @(posedge clk) begin
		if (rst_i) begin
			req_pend_q <= 1'b0;
			inv_pend_q <= 1'b0;
		end else begin
			if (req_valid_i)
				req_pend_q <= 1'b1;
			else if (take_req_i)
				req_pend_q <= 1'b0;
			// Newer invalidate simply replaces the pending one
			if (inv_i)
				inv_pend_q <= 1'b1;
			else if (take_inv_i)
				inv_pend_q <= 1'b0;
		end
	end

	// Request and invalidate payloads
	always_ff @(posedge clk) begin
		if (req_valid_i)
			req_q <= req_i;
		if (inv_i)
			inv_adr_q <= inv_adr_i;
	end

	assign req_pend_o = req_pend_q;
	assign req_o      = req_q;
	assign inv_pend_o = inv_pend_q;
	assign inv_adr_o  = inv_adr_q;
	// Busy while a request waits or the controller works on one
	assign busy_o     = req_pend_q | ~ctrl_idle_i;

endmodule

// ==== dc_top.sv ====
`timescale 1ns/1ps
`include "dc_defs.svh"

module dc_top import dc_pkg::*; (
	input  logic               clk,
	input  logic               rst_i,
	input  logic               req_valid_i,
	input  dc_req_t            req_i,
	input  logic               inv_i,
	input  logic [`DC_ABW-1:0] inv_adr_i,
	output logic               busy_o,
	output logic               done_o,
	output logic [`DC_DW-1:0]  rdata_o,
	output logic               err_o,
	output logic [31:0]        fill_cnt_o,
	output dc_bus_req_t        bus_o,
	input  logic               ack_i,
	input  logic               err_i,
	input  logic [`DC_DW-1:0]  dat_i
);

	// Capture to controller
	logic               req_pend, inv_pend, take_req, take_inv, ctrl_idle;
	dc_req_t            req_held;
	logic [`DC_ABW-1:0] inv_adr;

	// Controller to stores and bus master
	dc_store_cmd_t      l1_cmd, l2_cmd;
	dc_store_rsp_t      l1_rsp, l2_rsp;
	logic               l1_init, l2_init, fill_start;
	logic [`DC_ABW-1:0] fill_adr;
	dc_fill_t           fill;

	dc_req_capture u_cap (
		.clk, .rst_i, .req_valid_i, .req_i, .inv_i, .inv_adr_i,
		.take_req_i(take_req), .take_inv_i(take_inv), .ctrl_idle_i(ctrl_idle),
		.req_pend_o(req_pend), .req_o(req_held), .inv_pend_o(inv_pend),
		.inv_adr_o(inv_adr), .busy_o
	);

	dc_miss_ctrl u_ctrl (
		.clk, .rst_i, .req_pend_i(req_pend), .req_i(req_held),
		.inv_pend_i(inv_pend), .inv_adr_i(inv_adr),
		.take_req_o(take_req), .take_inv_o(take_inv), .idle_o(ctrl_idle),
		.l1_cmd_o(l1_cmd), .l1_rsp_i(l1_rsp), .l2_cmd_o(l2_cmd), .l2_rsp_i(l2_rsp),
		.l1_init_i(l1_init), .l2_init_i(l2_init),
		.fill_start_o(fill_start), .fill_adr_o(fill_adr), .fill_i(fill),
		.done_o, .rdata_o, .err_o, .fill_cnt_o
	);

	dc_line_store #(.LINES(`DC_L1_LINES)) u_l1 (
		.clk, .rst_i, .cmd_i(l1_cmd), .rsp_o(l1_rsp), .init_done_o(l1_init)
	);

	dc_line_store #(.LINES(`DC_L2_LINES)) u_l2 (
		.clk, .rst_i, .cmd_i(l2_cmd), .rsp_o(l2_rsp), .init_done_o(l2_init)
	);

	dc_bus_fill u_bus (
		.clk, .rst_i, .start_i(fill_start), .adr_i(fill_adr),
		.bus_o, .ack_i, .err_i, .dat_i, .fill_o(fill)
	);

endmodule

// ==== flist.f ====
+incdir+.
dc_pkg.sv
dc_req_capture.sv
dc_line_store.sv
dc_miss_ctrl.sv
dc_bus_fill.sv
dc_top.sv
tb_bus_mem.sv
tb_dc_top.sv

// ==== tb_bus_mem.sv ====
`timescale 1ns/1ps
`include "dc_defs.svh"

module tb_bus_mem import dc_pkg::*; (
	input  logic                 clk,
	input  logic                 rst_i,
	input  dc_bus_req_t          bus_i,
	input  logic                 bad_en_i,
	input  logic [`DC_ABW-5:0]   bad_line_i,
	input  logic [1:0]           bad_beat_i,
	output logic                 ack_o,
	output logic                 err_o,
	output logic [`DC_DW-1:0]    dat_o
);

	integer     seed;
	integer     rnd;
	logic [1:0] wait_q;
	logic       beat_bad;

	// Word value is its own word address, once in each half
	function automatic logic [`DC_DW-1:0] word_at(input logic [`DC_ABW-1:0] adr);
		logic [15:0] wa;
		wa = 16'(adr >> 2);
		return {wa, wa};
	endfunction

	// Beats of the bad line from the programmed beat onwards fail
	assign beat_bad = bad_en_i && (bus_i.adr[`DC_ABW-1:4] == bad_line_i)
		&& (bus_i.adr[3:2] >= bad_beat_i);

	initial begin
		seed   = 30;
		ack_o  = 1'b0;
		err_o  = 1'b0;
		dat_o  = '0;
		wait_q = '0;
	end

	// One answer per beat after 0 to 3 random wait cycles
	always @(posedge clk) begin
		if (rst_i) begin
			ack_o  <= 1'b0;
			err_o  <= 1'b0;
			wait_q <= '0;
		end else begin
			ack_o <= 1'b0;
			err_o <= 1'b0;
			// Skip the edge where the master takes the answer
			if (bus_i.cyc && bus_i.stb && !(ack_o || err_o)) begin
				if (wait_q == 2'd0) begin
					if (beat_bad) begin
						err_o <= 1'b1;
						dat_o <= 32'hdead_beef;
					end else begin
						ack_o <= 1'b1;
						dat_o <= word_at(bus_i.adr);
					end
					rnd    = $random(seed);
					wait_q <= rnd[1:0];
				end else begin
					wait_q <= wait_q - 2'd1;
				end
			end
		end
	end

endmodule

// ==== tb_dc_top.sv ====
`timescale 1ns/1ps
`include "dc_defs.svh"

module tb_dc_top import dc_pkg::*; ();

	localparam int RAND_OPS  = 40;
	localparam int TOTAL_OPS = 20 + RAND_OPS;
	localparam int NL1       = `DC_L1_LINES;
	localparam int NL2       = `DC_L2_LINES;
	localparam int LW        = `DC_ABW - 4;

	logic               clk;
	logic               rst_i;
	logic               req_valid;
	dc_req_t            req_d;
	logic               inv;
	logic [`DC_ABW-1:0] inv_adr;
	logic               busy;
	logic               done;
	logic               err;
	logic [`DC_DW-1:0]  rdata;
	logic [31:0]        fill_cnt;
	dc_bus_req_t        bus;
	logic               ack;
	logic               berr;
	logic [`DC_DW-1:0]  bdat;
	logic               bad_en;
	logic [LW-1:0]      bad_line;
	logic [1:0]         bad_beat;

	// Reference model state
	logic [LW-1:0]      l1_line [NL1];
	logic               l1_val [NL1];
	logic [LW-1:0]      l2_line [NL2];
	logic               l2_val [NL2];
	logic [`DC_DW-1:0]  ref_word [2**(`DC_ABW-2)];
	int                 exp_fills;
	int                 bursts;
	int                 seed;
	logic               op_busy;
	logic [`DC_ABW-1:0] exp_base;
	int                 mon_beat;
	logic               mon_end;

	dc_top uut (
		.clk, .rst_i, .req_valid_i(req_valid), .req_i(req_d), .inv_i(inv),
		.inv_adr_i(inv_adr), .busy_o(busy), .done_o(done), .rdata_o(rdata),
		.err_o(err), .fill_cnt_o(fill_cnt), .bus_o(bus), .ack_i(ack),
		.err_i(berr), .dat_i(bdat)
	);

	tb_bus_mem u_mem (
		.clk, .rst_i, .bus_i(bus), .bad_en_i(bad_en), .bad_line_i(bad_line),
		.bad_beat_i(bad_beat), .ack_o(ack), .err_o(berr), .dat_o(bdat)
	);

	initial begin
		clk = 1'b0;
		forever #5 clk = ~clk;
	end

	// ======================================================================
	// Failure reporting
	// ======================================================================

	task automatic report_mismatch(input string sig, input logic [31:0] exp_v,
		input logic [31:0] got_v);
		$display("Mismatch at %0t: %s expected %h, got %h", $time, sig, exp_v, got_v);
		$display("TEST RESULT: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	task automatic report_failure(input string what);
		$display("Error at %0t: %s", $time, what);
		$display("TEST RESULT: FAIL");
		$fatal(1, "stopped at first error");
	endtask

	// ======================================================================
	// Reference model
	// ======================================================================

	// Memory word, same address-derived pattern as the slave
	function automatic logic [`DC_DW-1:0] mem_word(input logic [`DC_ABW-1:0] adr);
		logic [15:0] wa;
		wa = 16'(adr >> 2);
		return {wa, wa};
	endfunction

	function automatic logic l1_holds(input logic [LW-1:0] ln);
		return l1_val[ln % NL1] && (l1_line[ln % NL1] == ln);
	endfunction

	function automatic logic l2_holds(input logic [LW-1:0] ln);
		return l2_val[ln % NL2] && (l2_line[ln % NL2] == ln);
	endfunction

	// Strobe on a rising edge, then wait for done_o
	// Delay counts edges after the one that samples the strobe
	task automatic run_request(input logic wr, input logic [`DC_ABW-1:0] adr,
		input logic [`DC_DW-1:0] wdat, input logic [3:0] sel, output int lat);
		@(posedge clk);
		while (busy)
			@(posedge clk);
		req_valid  <= 1'b1;
		req_d.rd   <= ~wr;
		req_d.wr   <= wr;
		req_d.adr  <= adr;
		req_d.wdat <= wdat;
		req_d.sel  <= sel;
		op_busy    <= 1'b1;
		@(posedge clk);
		req_valid <= 1'b0;
		lat = 0;
		do begin
			@(posedge clk);
			lat++;
		end while (!done);
		op_busy <= 1'b0;
	endtask

	task automatic check_read(input logic [`DC_ABW-1:0] adr);
		logic [LW-1:0] ln;
		logic          hit1;
		logic          hit2;
		logic          bad;
		int            lat;
		int            bursts0;
		ln      = adr[`DC_ABW-1:4];
		hit1    = l1_holds(ln);
		hit2    = l2_holds(ln);
		bad     = bad_en && (bad_line == ln) && !hit1 && !hit2;
		bursts0 = bursts;
		exp_base <= {ln, 4'h0};
		run_request(1'b0, adr, '0, '0, lat);
		// Good bus fill loads both levels from memory
		if (!hit1 && !hit2 && !bad) begin
			l2_line[ln % NL2] = ln;
			l2_val[ln % NL2]  = 1'b1;
			for (int w = 0; w < 4; w++)
				ref_word[{ln, 2'(w)}] = mem_word({ln, 2'(w), 2'b00});
			exp_fills++;
		end
		if (!hit1 && !bad) begin
			l1_line[ln % NL1] = ln;
			l1_val[ln % NL1]  = 1'b1;
		end
		assert (err === bad) else report_mismatch("err_o", bad, err);
		if (!bad)
			assert (rdata === ref_word[adr[`DC_ABW-1:2]])
			else report_mismatch("rdata_o", ref_word[adr[`DC_ABW-1:2]], rdata);
		assert (fill_cnt === exp_fills) else report_mismatch("fill_cnt_o", exp_fills, fill_cnt);
		assert (bursts == bursts0 + ((hit1 || hit2) ? 0 : 1))
		else report_mismatch("bus burst count", bursts0 + ((hit1 || hit2) ? 0 : 1), bursts);
		if (hit1)
			assert (lat == 3) else report_mismatch("done_o delay", 3, lat);
		// An L1 miss has to go through the L2 or bus path
		if (!hit1)
			assert (lat > 3) else report_failure("L1 miss completed at L1 hit speed");
	endtask

	// Merge only where a level already holds the line
	task automatic check_write(input logic [`DC_ABW-1:0] adr, input logic [`DC_DW-1:0] wdat,
		input logic [3:0] sel);
		logic [LW-1:0] ln;
		int            lat;
		int            bursts0;
		ln      = adr[`DC_ABW-1:4];
		bursts0 = bursts;
		if (l1_holds(ln) || l2_holds(ln)) begin
			for (int b = 0; b < 4; b++)
				if (sel[b])
					ref_word[adr[`DC_ABW-1:2]][b*8 +: 8] = wdat[b*8 +: 8];
		end
		run_request(1'b1, adr, wdat, sel, lat);
		assert (lat == 3) else report_mismatch("done_o delay", 3, lat);
		assert (err === 1'b0) else report_mismatch("err_o", 0, err);
		assert (bursts == bursts0) else report_mismatch("bus burst count", bursts0, bursts);
	endtask

	// Clears the L1 index whatever line sits there
	task automatic do_invalidate(input logic [`DC_ABW-1:0] adr);
		@(posedge clk);
		inv     <= 1'b1;
		inv_adr <= adr;
		@(posedge clk);
		inv <= 1'b0;
		l1_val[adr[`DC_ABW-1:4] % NL1] = 1'b0;
		repeat (2) @(posedge clk);
	endtask

	task automatic program_bad_line(input logic en, input logic [LW-1:0] ln,
		input logic [1:0] beat);
		bad_en   <= en;
		bad_line <= ln;
		bad_beat <= beat;
		@(posedge clk);
	endtask

	// ======================================================================
	// Bus and done monitor
	// ======================================================================

	always @(posedge clk) begin
		if (rst_i) begin
			mon_beat = 0;
			mon_end  = 1'b0;
			bursts <= 0;
		end else begin
			assert (!(done && !op_busy)) else report_failure("done_o with no request in flight");
			if (mon_end) begin
				assert (!bus.cyc) else report_failure("bus cyc still high after the burst");
				mon_end = 1'b0;
			end else if (bus.cyc) begin
				assert (bus.stb) else report_mismatch("bus_o.stb", 1, bus.stb);
				assert (bus.adr === exp_base + `DC_ABW'(4 * mon_beat))
				else report_mismatch("bus_o.adr", exp_base + `DC_ABW'(4 * mon_beat), bus.adr);
				assert (bus.cti === ((mon_beat == 3) ? 3'd7 : 3'd2))
				else report_mismatch("bus_o.cti", (mon_beat == 3) ? 7 : 2, bus.cti);
				// Beat ends on ack or err, burst on err or fourth ack
				if (ack || berr) begin
					if (berr || mon_beat == 3) begin
						mon_end  = 1'b1;
						mon_beat = 0;
						bursts <= bursts + 1;
					end else begin
						mon_beat++;
					end
				end
			end
		end
	end

	// Watchdog, generous budget per operation plus reset sweep
	initial begin
		repeat ((TOTAL_OPS + 1) * 200) @(posedge clk);
		report_failure("watchdog expired before the sequence finished");
	end

	// ======================================================================
	// Stimulus
	// ======================================================================

	initial begin
		int                 sweep;
		int                 r;
		int                 kind;
		logic [`DC_ABW-1:0] adr;
		seed      = 30;
		rst_i     = 1'b1;
		req_valid = 1'b0;
		req_d     = '0;
		inv       = 1'b0;
		inv_adr   = '0;
		bad_en    = 1'b0;
		bad_line  = '0;
		bad_beat  = '0;
		op_busy   = 1'b0;
		exp_fills = 0;
		exp_base  = '0;
		for (int i = 0; i < NL1; i++)
			l1_val[i] = 1'b0;
		for (int i = 0; i < NL2; i++)
			l2_val[i] = 1'b0;
		repeat (4) @(posedge clk);
		assert (done === 1'b0 && err === 1'b0) else report_failure("done_o or err_o high in reset");
		assert (fill_cnt === 32'd0) else report_mismatch("fill_cnt_o", 0, fill_cnt);
		assert (bus.cyc === 1'b0) else report_mismatch("bus_o.cyc", 0, bus.cyc);
		rst_i <= 1'b0;
		// Valid sweep keeps busy_o high for a full L2 pass
		sweep = 0;
		@(posedge clk);
		while (busy) begin
			@(posedge clk);
			sweep++;
		end
		assert (sweep >= NL2) else report_mismatch("busy_o sweep cycles", NL2, sweep);

		// Cold miss, then L1 hits
		check_read(16'h1234);
		check_read(16'h1234);
		check_read(16'h1238);
		// L1 copy gone, L2 still has it
		do_invalidate(16'h1230);
		check_read(16'h123c);
		// Same L1 index from a different L2 index
		check_read(16'h1334);
		check_read(16'h1230);
		// Partial writes, both levels then L2 only
		check_write(16'h1234, 32'haabb_ccdd, 4'b0101);
		check_read(16'h1234);
		do_invalidate(16'h1234);
		check_write(16'h1238, 32'h1122_3344, 4'b1000);
		check_read(16'h1238);
		// Write to an uncached line is dropped
		check_write(16'h4000, 32'hffff_ffff, 4'b1111);
		check_read(16'h4000);
		// L2 conflict refetches from memory, earlier writes lost
		check_read(16'h1630);
		check_read(16'h1234);
		// Error on the third beat, twice, then a clean fill
		program_bad_line(1'b1, 12'h567, 2'd2);
		check_read(16'h5674);
		check_read(16'h5678);
		program_bad_line(1'b0, 12'h567, 2'd2);
		check_read(16'h5670);

		// Random mix over a few conflicting lines
		for (int n = 0; n < RAND_OPS; n++) begin
			r    = $random(seed);
			kind = $random(seed);
			adr  = r[15:0] & 16'h0d3c;
			if (kind[3:0] < 9)
				check_read(adr);
			else if (kind[3:0] < 13)
				check_write(adr, $random(seed), kind[7:4]);
			else
				do_invalidate(adr);
		end

		repeat (5) @(posedge clk);
		$display("TEST RESULT: PASS");
		$finish;
	end

endmodule
